//--- src.f
rtl/mult_pkg.sv
rtl/apb_regs_pkg.sv
rtl/kogge_stone_adder.sv
rtl/dadda_reduction.sv
rtl/dadda_multiplier.sv
rtl/mult_apb_regs.sv
rtl/apb_multiplier.sv
tb/apb_multiplier_assertions.sv
tb/tb_apb_multiplier.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB multiplier testbench with Verilator.

cd "$(dirname "$0")" || exit 1

TOP=tb_apb_multiplier
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- tb/tb_apb_multiplier.sv
`timescale 1ns/1ps

module tb_apb_multiplier import apb_regs_pkg::*, mult_pkg::*; ();

    localparam int PREADY_TIMEOUT = 16;  // cycles
    localparam int WRAP_WRITES    = 260;
    localparam int RANDOM_PAIRS   = 200;

    typedef struct packed {
        apb_addr_t addr;
        logic      write;
        apb_data_t data;
        apb_data_t exp_rdata;  // zero for erroring reads
        logic      exp_err;
    } stim_row_t;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    stim_row_t stim_q[$];
    count_t    model_count;  // accepted operand writes

    apb_multiplier uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_test();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input apb_data_t actual, input apb_data_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            abort_test();
        end
    endtask

    // setup on one falling edge, access on the next, sampled 1 ns later
    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin
            if (waits >= PREADY_TIMEOUT) begin
                $display("Timeout: no pready within %0d cycles at address 0x%h",
                         PREADY_TIMEOUT, addr);
                abort_test();
            end
            @(negedge clk);
            #1;
            waits++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);  // rising edge in between ends the access
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused_rdata;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic add_row(input apb_addr_t addr, input logic write, input apb_data_t data,
                           input apb_data_t exp_rdata, input logic exp_err);
        stim_row_t row;
        row.addr      = addr;
        row.write     = write;
        row.data      = data;
        row.exp_rdata = exp_rdata;
        row.exp_err   = exp_err;
        stim_q.push_back(row);
    endtask

    task automatic build_table();
        add_row(ADDR_OPERAND, 1'b0, 32'h0, 32'h0, 1'b0);  // reset values
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0, 1'b0);
        add_row(ADDR_COUNT,   1'b0, 32'h0, 32'h0, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_0000, 32'h0, 1'b0);  // 0 x 0
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_0000, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_FFFF, 32'h0, 1'b0);  // 255 x 255
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_FE01, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_FF01, 32'h0, 1'b0);  // 1 x 255
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_00FF, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_0180, 32'h0, 1'b0);  // 0x80 x 0x01
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_0080, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_4010, 32'h0, 1'b0);  // 0x10 x 0x40
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_0400, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_8080, 32'h0, 1'b0);  // 0x80 x 0x80
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_4000, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'hDEAD_55AA, 32'h0, 1'b0);  // upper bits dropped
        add_row(ADDR_OPERAND, 1'b0, 32'h0, 32'h0000_55AA, 1'b0);
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_3872, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_AA55, 32'h0, 1'b0);  // 0x55 x 0xAA
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_3872, 1'b0);
        add_row(ADDR_OPERAND, 1'b1, 32'h0000_0FF0, 32'h0, 1'b0);  // 0xF0 x 0x0F
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_0E10, 1'b0);
        add_row(ADDR_COUNT,   1'b0, 32'h0, 32'h0000_0009, 1'b0);
        add_row(ADDR_RESULT,  1'b1, 32'h0000_1234, 32'h0, 1'b1);  // read only
        add_row(ADDR_COUNT,   1'b1, 32'h0000_0055, 32'h0, 1'b1);
        add_row(4'hC,         1'b1, 32'h0000_0101, 32'h0, 1'b1);  // unknown offset
        add_row(4'hC,         1'b0, 32'h0, 32'h0, 1'b1);
        add_row(4'h1,         1'b1, 32'h0000_0202, 32'h0, 1'b1);  // unaligned
        add_row(4'h6,         1'b0, 32'h0, 32'h0, 1'b1);
        add_row(ADDR_RESULT,  1'b0, 32'h0, 32'h0000_0E10, 1'b0);  // nothing changed
        add_row(ADDR_OPERAND, 1'b0, 32'h0, 32'h0000_0FF0, 1'b0);
        add_row(ADDR_COUNT,   1'b0, 32'h0, 32'h0000_0009, 1'b0);
    endtask

    initial begin
        stim_row_t   row;
        apb_data_t   rdata;
        logic        err;
        operand_t    a;
        operand_t    b;
        product_t    expected;

        void'($urandom(44));
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        model_count = '0;
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (stim_q[i]) begin
            row = stim_q[i];
            if (row.write) begin
                apb_write(row.addr, row.data, err);
                if (row.addr == ADDR_OPERAND && !row.exp_err) begin
                    model_count = model_count + 8'd1;
                end
            end else begin
                apb_read(row.addr, rdata, err);
                check_value(rdata, row.exp_rdata, $sformatf("row %0d read data", i));
            end
            check_value(32'(err), 32'(row.exp_err), $sformatf("row %0d pslverr", i));
        end

        // push the count past 255
        for (int n = 0; n < WRAP_WRITES; n++) begin
            apb_write(ADDR_OPERAND, apb_data_t'(n), err);
            check_value(32'(err), 32'd0, "pslverr on operand write");
            model_count = model_count + 8'd1;
        end
        apb_read(ADDR_COUNT, rdata, err);
        check_value(rdata, 32'(model_count), "count after wrap");

        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            a        = operand_t'($urandom());
            b        = operand_t'($urandom());
            expected = product_t'(a) * product_t'(b);
            apb_write(ADDR_OPERAND, {16'h0000, b, a}, err);
            check_value(32'(err), 32'd0, "pslverr on random operand write");
            model_count = model_count + 8'd1;
            apb_read(ADDR_RESULT, rdata, err);
            check_value(rdata, 32'(expected), $sformatf("product of %0d and %0d", a, b));
        end
        apb_read(ADDR_COUNT, rdata, err);
        check_value(rdata, 32'(model_count), "count after random pairs");

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tb/apb_multiplier_assertions.sv
`timescale 1ns/1ps

module apb_multiplier_assertions import mult_pkg::*, apb_regs_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      psel,
    input logic      penable,
    input logic      pwrite,
    input apb_addr_t paddr,
    input logic      pready,
    input logic      pslverr,
    input operand_t  operand_a,
    input operand_t  operand_b,
    input product_t  product
);

    logic operand_accept;

    assign operand_accept = psel && penable && pwrite && (paddr == ADDR_OPERAND) && !pslverr;

    pready_high: assert property (@(posedge clk) disable iff (reset) pready)
        else $error("pready dropped low");

    err_in_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable))
        else $error("pslverr high outside an access phase");

    // operands land on the write edge, product settles before the next
    product_match: assert property (@(posedge clk) disable iff (reset)
        operand_accept |=> (product == product_t'(operand_a) * product_t'(operand_b)))
        else $error("product does not match the registered operands");

endmodule

bind mult_apb_regs apb_multiplier_assertions u_assertions (
    .clk (clk), .reset (reset), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pready (pready), .pslverr (pslverr), .operand_a (operand_a),
    .operand_b (operand_b), .product (product)
);

//--- rtl/apb_multiplier.sv
`timescale 1ns/1ps

module apb_multiplier import mult_pkg::*, apb_regs_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr
);

    operand_t operand_a;
    operand_t operand_b;
    product_t product;  // combinational, registered in u_regs

    mult_apb_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .product   (product)
    );

    dadda_multiplier u_mult (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .product   (product)
    );

endmodule

//--- rtl/mult_apb_regs.sv
`timescale 1ns/1ps

module mult_apb_regs import mult_pkg::*, apb_regs_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output operand_t  operand_a,
    output operand_t  operand_b,
    input  product_t  product
);

    logic      access;
    logic      addr_hit;
    logic      addr_err;
    logic      write_err;
    logic      operand_wr;
    logic      load_pulse;  // product valid one edge after the write
    product_t  result_q;
    count_t    count_q;
    apb_data_t rd_mux;

    assign pready = 1'b1;  // no wait states
    assign access = psel & penable;

    assign addr_hit = (paddr == ADDR_OPERAND) || (paddr == ADDR_RESULT) ||
                      (paddr == ADDR_COUNT);
    assign addr_err  = (paddr[1:0] != 2'b00) || !addr_hit;
    assign write_err = pwrite && (paddr != ADDR_OPERAND);  // result, count read only

    assign pslverr    = access & (addr_err | write_err);
    assign operand_wr = access & pwrite & (paddr == ADDR_OPERAND);

    always_comb begin
        case (paddr)
            ADDR_OPERAND: rd_mux = apb_data_t'({operand_b, operand_a});
            ADDR_RESULT:  rd_mux = apb_data_t'(result_q);
            ADDR_COUNT:   rd_mux = apb_data_t'(count_q);
            default:      rd_mux = '0;
        endcase
    end

    assign prdata = (access && !pwrite) ? rd_mux : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            operand_a  <= '0;
            operand_b  <= '0;
            load_pulse <= 1'b0;
            result_q   <= '0;
            count_q    <= '0;
        end else begin
            load_pulse <= operand_wr;
            if (operand_wr) begin
                operand_a <= pwdata[OPERAND_W-1:0];
                operand_b <= pwdata[2*OPERAND_W-1:OPERAND_W];
            end
            if (load_pulse) begin
                result_q <= product;
                count_q  <= count_q + 1'b1;  // wraps
            end
        end
    end

endmodule

//--- rtl/dadda_multiplier.sv
`timescale 1ns/1ps

module dadda_multiplier import mult_pkg::*; (
    input  operand_t operand_a,
    input  operand_t operand_b,
    output product_t product
);

    pp_row_t    pp [OPERAND_W];
    logic [1:0] low_bits;   // product bits 1:0
    red_row_t   row_sum;
    red_row_t   row_carry;
    red_row_t   final_sum;
    logic       final_cout;

    // AND-gated partial products
    for (genvar i = 0; i < OPERAND_W; i++) begin : g_pp
        assign pp[i] = operand_b & {OPERAND_W{operand_a[i]}};
    end

    dadda_reduction u_red (
        .pp0       (pp[0]),
        .pp1       (pp[1]),
        .pp2       (pp[2]),
        .pp3       (pp[3]),
        .pp4       (pp[4]),
        .pp5       (pp[5]),
        .pp6       (pp[6]),
        .pp7       (pp[7]),
        .low_bits  (low_bits),
        .row_sum   (row_sum),
        .row_carry (row_carry)
    );

    kogge_stone_adder #(.WIDTH(RED_ROW_W)) u_final (
        .in1  (row_sum),
        .in2  (row_carry),
        .cin  (1'b0),
        .sum  (final_sum),
        .cout (final_cout)
    );

    assign product = {final_cout, final_sum, low_bits};  // carry out is bit 15

endmodule

//--- rtl/dadda_reduction.sv
`timescale 1ns/1ps

module dadda_reduction import mult_pkg::*; (
    input  pp_row_t    pp0,
    input  pp_row_t    pp1,
    input  pp_row_t    pp2,
    input  pp_row_t    pp3,
    input  pp_row_t    pp4,
    input  pp_row_t    pp5,
    input  pp_row_t    pp6,
    input  pp_row_t    pp7,
    output logic [1:0] low_bits,
    output red_row_t   row_sum,
    output red_row_t   row_carry
);

    logic [3:0] s1, s2, s3, s4, s5, s7, s8, s9;
    logic [1:0] s6;
    logic       c1, c2, c3, c4, c5, c6, c7, c8, c9;
    logic       ha_c;

    // full adders for columns 2 to 9, one per bit
    logic [7:0] fa_x;
    logic [7:0] fa_y;
    logic [7:0] fa_z;
    logic [7:0] fa_s;
    logic [7:0] fa_c;

    kogge_stone_adder #(.WIDTH(4)) u_ks1 (  // weights 6..9
        .in1 (pp2[7:4]), .in2 (pp3[6:3]), .cin (1'b0), .sum (s1), .cout (c1)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks2 (  // weights 5..8
        .in1 (pp4[4:1]), .in2 (pp5[3:0]), .cin (1'b0), .sum (s2), .cout (c2)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks3 (  // weights 7..10
        .in1 (pp6[4:1]), .in2 (pp7[3:0]), .cin (1'b0), .sum (s3), .cout (c3)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks4 (  // weights 3..6
        .in1 (pp0[6:3]), .in2 (pp1[5:2]), .cin (1'b0), .sum (s4), .cout (c4)
    );

    // weights 7..10, s3[0] folded in as carry
    kogge_stone_adder #(.WIDTH(4)) u_ks5 (
        .in1  ({pp3[7], pp4[5], pp1[7], pp0[7]}),
        .in2  ({pp4[6], pp5[4], s1[2], pp1[6]}),
        .cin  (s3[0]),
        .sum  (s5),
        .cout (c5)
    );

    kogge_stone_adder #(.WIDTH(2)) u_ks6 (  // weights 11..12
        .in1  ({pp5[7], pp4[7]}),
        .in2  ({pp6[6], pp5[6]}),
        .cin  (pp6[5]),
        .sum  (s6),
        .cout (c6)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks7 (  // weights 4..7
        .in1  ({s1[1], pp6[0], pp2[3:2]}),
        .in2  ({s2[2], s1[0], pp3[2:1]}),
        .cin  (1'b0),
        .sum  (s7),
        .cout (c7)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks8 (  // weights 8..11
        .in1  ({c3, pp5[5], s1[3], s2[3]}),
        .in2  ({pp7[4], c1, c2, s3[1]}),
        .cin  (1'b0),
        .sum  (s8),
        .cout (c8)
    );

    kogge_stone_adder #(.WIDTH(4)) u_ks9 (  // weights 10..13
        .in1  ({pp6[7], pp7[5], c5, s3[3]}),
        .in2  ({pp7[6], s6[1], s6[0], s5[3]}),
        .cin  (s8[2]),
        .sum  (s9),
        .cout (c9)
    );

    // column 1 needs only a half adder
    assign low_bits[0] = pp0[0];
    assign low_bits[1] = pp0[1] ^ pp1[0];
    assign ha_c        = pp0[1] & pp1[0];

    assign fa_x = {s3[2], s5[1], c4, s2[1], s2[0], pp4[0], pp2[1], pp0[2]};
    assign fa_y = {s5[2], c7, s5[0], s4[3], s4[2], s4[1], pp3[0], pp1[1]};
    assign fa_z = {s8[1], s8[0], s7[3], s7[2], s7[1], s7[0], s4[0], pp2[0]};

    assign fa_s = fa_x ^ fa_y ^ fa_z;
    assign fa_c = (fa_x & fa_y) | (fa_x & fa_z) | (fa_y & fa_z);

    // both rows start at weight 2
    assign row_sum   = {pp7[7], s9, fa_s};
    assign row_carry = {c9, c6, c8, s8[3], fa_c, ha_c};

endmodule

//--- rtl/kogge_stone_adder.sv
`timescale 1ns/1ps

module kogge_stone_adder #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    // position 0 holds the carry in, operand bits sit at 1..WIDTH
    localparam int N      = WIDTH + 1;
    localparam int LEVELS = $clog2(N);

    logic [LEVELS:0][N-1:0] g;  // group generate per level
    logic [LEVELS:0][N-1:0] p;  // group propagate per level

    assign g[0] = {in1 & in2, cin};
    assign p[0] = {in1 ^ in2, 1'b0};

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int D = 1 << lvl;

        for (genvar i = 0; i < N; i++) begin : g_bit
            if (i < D) begin : g_pass
                // already resolved down to the carry in
                assign g[lvl+1][i] = g[lvl][i];
                assign p[lvl+1][i] = p[lvl][i];
            end else if (i < 2 * D) begin : g_gray
                // lower group reaches position 0, only g is needed
                assign g[lvl+1][i] = g[lvl][i] | (p[lvl][i] & g[lvl][i-D]);
                assign p[lvl+1][i] = 1'b0;
            end else begin : g_black
                assign g[lvl+1][i] = g[lvl][i] | (p[lvl][i] & g[lvl][i-D]);
                assign p[lvl+1][i] = p[lvl][i] & p[lvl][i-D];
            end
        end
    end

    // carry into bit i is the prefix generate of positions i..0
    assign sum  = p[0][N-1:1] ^ g[LEVELS][N-2:0];
    assign cout = g[LEVELS][N-1];

endmodule

//--- rtl/apb_regs_pkg.sv
package apb_regs_pkg;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;
    localparam int COUNT_W    = 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // wraps at 256
    typedef logic [COUNT_W-1:0] count_t;

    // register offsets
    localparam apb_addr_t ADDR_OPERAND = 4'h0;  // a in 7:0, b in 15:8
    localparam apb_addr_t ADDR_RESULT  = 4'h4;  // read only
    localparam apb_addr_t ADDR_COUNT   = 4'h8;  // read only

endpackage

//--- rtl/mult_pkg.sv
package mult_pkg;

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // two product bits leave the reduction finished
    localparam int RED_ROW_W = PRODUCT_W - 3;

    // one multiplicand
    typedef logic [OPERAND_W-1:0] operand_t;

    typedef logic [PRODUCT_W-1:0] product_t;

    // operand_b gated by one bit of operand_a
    typedef logic [OPERAND_W-1:0] pp_row_t;

    // rows into the final adder, weights 2 to 14
    typedef logic [RED_ROW_W-1:0] red_row_t;

endpackage
